// ==== global_buffer.f ====
hw/global_buffer_pkg.sv
hw/cfg_ifc.sv
hw/glb_tile_bank.sv
hw/glb_tile_cfg.sv
hw/glb_tile.sv
hw/glb_chain_start.sv
hw/global_buffer.sv
verif/global_buffer_props.sv
verif/tb_global_buffer.sv

// ==== hw/cfg_ifc.sv ====
`timescale 1ns/1ps

interface cfg_ifc;
    import global_buffer_pkg::*;

    logic                      wr_en;          // Single cycle write strobe
    logic [CFG_ADDR_WIDTH-1:0] wr_addr;
    logic [CFG_DATA_WIDTH-1:0] wr_data;
    logic                      rd_en;          // Single cycle read strobe
    logic [CFG_ADDR_WIDTH-1:0] rd_addr;
    logic [CFG_DATA_WIDTH-1:0] rd_data;        // Zero unless the addressed tile answers
    logic                      rd_data_valid;

    // Requester side
    modport master (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_data, rd_data_valid
    );

    modport slave (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data, rd_data_valid
    );

endinterface

// ==== hw/glb_chain_start.sv ====
`timescale 1ns/1ps

module glb_chain_start (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        proc_wr_en,
    input  logic [global_buffer_pkg::BANK_STRB_WIDTH-1:0] proc_wr_strb,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                        proc_rd_en,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_rd_data,
    output logic                                        proc_rd_data_valid,
    cfg_ifc.slave                                       if_cfg,
    cfg_ifc.master                                      if_cfg_est_m,
    input  global_buffer_pkg::packet_t                  proc_packet_esti,
    output global_buffer_pkg::packet_t                  proc_packet_esto
);
    import global_buffer_pkg::*;

    // Request packet leaves one edge after the processor strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            proc_packet_esto <= '0;                       // No request in flight after reset
        end else begin
            proc_packet_esto.wr.wr_en     <= proc_wr_en;
            proc_packet_esto.wr.wr_strb   <= proc_wr_strb;
            proc_packet_esto.wr.wr_addr   <= proc_wr_addr;
            proc_packet_esto.wr.wr_data   <= proc_wr_data;
            proc_packet_esto.rdrq.rd_en   <= proc_rd_en;
            proc_packet_esto.rdrq.rd_addr <= proc_rd_addr;
            proc_packet_esto.rdrs         <= '0;          // Tiles fill in the response
        end
    end

    // The returned response flag is the last stage of the fixed read latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            proc_rd_data_valid <= 1'b0;
        end else begin
            proc_rd_data_valid <= proc_packet_esti.rdrs.rd_data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_packet_esti.rdrs.rd_data_valid) begin
            proc_rd_data <= proc_packet_esti.rdrs.rd_data;  // Held until the next response
        end
    end

    assign if_cfg_est_m.wr_en   = if_cfg.wr_en;           // Config requests go east untouched
    assign if_cfg_est_m.wr_addr = if_cfg.wr_addr;
    assign if_cfg_est_m.wr_data = if_cfg.wr_data;
    assign if_cfg_est_m.rd_en   = if_cfg.rd_en;
    assign if_cfg_est_m.rd_addr = if_cfg.rd_addr;
    assign if_cfg.rd_data       = if_cfg_est_m.rd_data;   // Already ORed over all tiles
    assign if_cfg.rd_data_valid = if_cfg_est_m.rd_data_valid;

endmodule

// ==== hw/glb_tile.sv ====
`timescale 1ns/1ps

module glb_tile (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic [global_buffer_pkg::TILE_ID_WIDTH-1:0] tile_id,
    input  global_buffer_pkg::packet_t                  proc_packet_wsti,
    output global_buffer_pkg::packet_t                  proc_packet_esto,
    cfg_ifc.slave                                       if_cfg_wst_s,
    cfg_ifc.master                                      if_cfg_est_m
);
    import global_buffer_pkg::*;

    logic                       wr_hit;        // Write addressed to this tile
    logic                       rd_hit;        // Read addressed to this tile
    logic                       rd_hit_q;      // Bank data is on rd_data this cycle
    logic                       wr_lock;
    logic                       bank_wr;
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data;
    packet_t                    packet_q;

    cfg_ifc if_cfg_loc ();                     // Private link to this tile's registers

    assign wr_hit  = proc_packet_wsti.wr.wr_en &&
                     (proc_packet_wsti.wr.wr_addr[TILE_SEL_LSB +: TILE_ID_WIDTH] == tile_id);
    assign rd_hit  = proc_packet_wsti.rdrq.rd_en &&
                     (proc_packet_wsti.rdrq.rd_addr[TILE_SEL_LSB +: TILE_ID_WIDTH] == tile_id);
    assign bank_wr = wr_hit && !wr_lock;       // Locked tiles drop writes silently

    glb_tile_bank u_bank (
        .clk     (clk),
        .wr_en   (bank_wr),
        .wr_strb (proc_packet_wsti.wr.wr_strb),
        .wr_word (proc_packet_wsti.wr.wr_addr[BANK_BYTE_OFFSET +: BANK_WORD_WIDTH]),
        .wr_data (proc_packet_wsti.wr.wr_data),
        .rd_en   (rd_hit),
        .rd_word (proc_packet_wsti.rdrq.rd_addr[BANK_BYTE_OFFSET +: BANK_WORD_WIDTH]),
        .rd_data (bank_rd_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            packet_q <= '0;
            rd_hit_q <= 1'b0;
        end else begin
            packet_q <= proc_packet_wsti;      // One register stage per tile
            rd_hit_q <= rd_hit;
        end
    end

    // Bank output lines up with the registered packet, so it is merged after the register
    always_comb begin
        proc_packet_esto = packet_q;
        if (rd_hit_q) begin
            proc_packet_esto.rdrs.rd_data_valid = 1'b1;
            proc_packet_esto.rdrs.rd_data       = bank_rd_data;
        end
    end

    glb_tile_cfg u_cfg (
        .clk     (clk),
        .arst_n  (arst_n),
        .tile_id (tile_id),
        .if_cfg  (if_cfg_loc),
        .bank_wr (bank_wr),
        .wr_lock (wr_lock)
    );

    assign if_cfg_loc.wr_en     = if_cfg_wst_s.wr_en;     // Same request to local regs and east
    assign if_cfg_loc.wr_addr   = if_cfg_wst_s.wr_addr;
    assign if_cfg_loc.wr_data   = if_cfg_wst_s.wr_data;
    assign if_cfg_loc.rd_en     = if_cfg_wst_s.rd_en;
    assign if_cfg_loc.rd_addr   = if_cfg_wst_s.rd_addr;
    assign if_cfg_est_m.wr_en   = if_cfg_wst_s.wr_en;
    assign if_cfg_est_m.wr_addr = if_cfg_wst_s.wr_addr;
    assign if_cfg_est_m.wr_data = if_cfg_wst_s.wr_data;
    assign if_cfg_est_m.rd_en   = if_cfg_wst_s.rd_en;
    assign if_cfg_est_m.rd_addr = if_cfg_wst_s.rd_addr;
    assign if_cfg_wst_s.rd_data = if_cfg_loc.rd_data | if_cfg_est_m.rd_data;
    assign if_cfg_wst_s.rd_data_valid = if_cfg_loc.rd_data_valid | if_cfg_est_m.rd_data_valid;

endmodule

// ==== hw/glb_tile_bank.sv ====
`timescale 1ns/1ps

module glb_tile_bank (
    input  logic                                          clk,
    input  logic                                          wr_en,
    input  logic [global_buffer_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [global_buffer_pkg::BANK_WORD_WIDTH-1:0] wr_word,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] wr_data,
    input  logic                                          rd_en,
    input  logic [global_buffer_pkg::BANK_WORD_WIDTH-1:0] rd_word,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] rd_data
);
    import global_buffer_pkg::*;

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_WORDS];  // One word per row with bytes picked by strobe

    // Byte lane writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_word][b*8 +: 8] <= wr_data[b*8 +: 8];  // Unstrobed bytes keep their value
                end
            end
        end
    end

    // A read that hits a word being written in the same cycle sees the old data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_word];
        end
    end

endmodule

// ==== hw/glb_tile_cfg.sv ====
`timescale 1ns/1ps

module glb_tile_cfg (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic [global_buffer_pkg::TILE_ID_WIDTH-1:0] tile_id,
    cfg_ifc.slave                                       if_cfg,
    input  logic                                        bank_wr,
    output logic                                        wr_lock
);
    import global_buffer_pkg::*;

    logic                      wr_match;    // Config write aimed at this tile
    logic                      rd_match;    // Config read aimed at this tile
    glb_cfg_reg_e              wr_sel;
    glb_cfg_reg_e              rd_sel;
    logic                      lock_q;
    logic [CFG_DATA_WIDTH-1:0] scratch_q;
    logic [CFG_DATA_WIDTH-1:0] wr_count_q;
    logic [CFG_DATA_WIDTH-1:0] rd_value;

    assign wr_match = if_cfg.wr_en && (if_cfg.wr_addr[CFG_TILE_SEL_LSB +: TILE_ID_WIDTH] == tile_id);
    assign rd_match = if_cfg.rd_en && (if_cfg.rd_addr[CFG_TILE_SEL_LSB +: TILE_ID_WIDTH] == tile_id);
    assign wr_sel   = glb_cfg_reg_e'(if_cfg.wr_addr[CFG_REG_SEL_WIDTH-1:0]);
    assign rd_sel   = glb_cfg_reg_e'(if_cfg.rd_addr[CFG_REG_SEL_WIDTH-1:0]);
    assign wr_lock  = lock_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lock_q     <= 1'b0;
            scratch_q  <= '0;
            wr_count_q <= '0;
        end else begin
            if (wr_match && wr_sel == CFG_LOCK)    lock_q    <= if_cfg.wr_data[0];
            if (wr_match && wr_sel == CFG_SCRATCH) scratch_q <= if_cfg.wr_data;
            if (wr_match && wr_sel == CFG_WR_COUNT) begin
                wr_count_q <= '0;                                // Clear wins over a same cycle write
            end else if (bank_wr) begin
                wr_count_q <= wr_count_q + 1'b1;                 // Only writes the lock let through
            end
        end
    end

    always_comb begin
        case (rd_sel)
            CFG_LOCK:     rd_value = CFG_DATA_WIDTH'(lock_q);
            CFG_SCRATCH:  rd_value = scratch_q;
            CFG_WR_COUNT: rd_value = wr_count_q;
            default:      rd_value = CFG_DATA_WIDTH'(tile_id);  // CFG_TILE_ID
        endcase
    end

    // Response must stay zero when idle since tiles OR their answers together
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_cfg.rd_data_valid <= 1'b0;
            if_cfg.rd_data       <= '0;
        end else begin
            if_cfg.rd_data_valid <= rd_match;
            if_cfg.rd_data       <= rd_match ? rd_value : '0;
        end
    end

endmodule

// ==== hw/global_buffer.sv ====
`timescale 1ns/1ps

module global_buffer (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          proc_wr_en,
    input  logic [global_buffer_pkg::BANK_STRB_WIDTH-1:0] proc_wr_strb,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_wr_addr,
    input  logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_wr_data,
    input  logic                                          proc_rd_en,
    input  logic [global_buffer_pkg::GLB_ADDR_WIDTH-1:0]  proc_rd_addr,
    output logic [global_buffer_pkg::BANK_DATA_WIDTH-1:0] proc_rd_data,
    output logic                                          proc_rd_data_valid,
    input  logic                                          cfg_wr_en,
    input  logic [global_buffer_pkg::CFG_ADDR_WIDTH-1:0]  cfg_wr_addr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0]  cfg_wr_data,
    input  logic                                          cfg_rd_en,
    input  logic [global_buffer_pkg::CFG_ADDR_WIDTH-1:0]  cfg_rd_addr,
    output logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0]  cfg_rd_data,
    output logic                                          cfg_rd_data_valid
);
    import global_buffer_pkg::*;

    packet_t packet_chain [NUM_GLB_TILES+1];  // Entry k feeds tile k and the last entry loops home

    cfg_ifc if_cfg_top ();                      // Outside config bus
    cfg_ifc if_cfg_chain [NUM_GLB_TILES+1] ();  // Entry k is the west side of tile k

    assign if_cfg_top.wr_en   = cfg_wr_en;
    assign if_cfg_top.wr_addr = cfg_wr_addr;
    assign if_cfg_top.wr_data = cfg_wr_data;
    assign if_cfg_top.rd_en   = cfg_rd_en;
    assign if_cfg_top.rd_addr = cfg_rd_addr;
    assign cfg_rd_data        = if_cfg_top.rd_data;
    assign cfg_rd_data_valid  = if_cfg_top.rd_data_valid;

    assign if_cfg_chain[NUM_GLB_TILES].rd_data       = '0;  // Nothing east of the last tile
    assign if_cfg_chain[NUM_GLB_TILES].rd_data_valid = 1'b0;

    glb_chain_start u_start (
        .clk, .arst_n,
        .proc_wr_en, .proc_wr_strb, .proc_wr_addr, .proc_wr_data,
        .proc_rd_en, .proc_rd_addr, .proc_rd_data, .proc_rd_data_valid,
        .if_cfg           (if_cfg_top),
        .if_cfg_est_m     (if_cfg_chain[0]),
        .proc_packet_esti (packet_chain[NUM_GLB_TILES]),  // Loop back from the east end
        .proc_packet_esto (packet_chain[0])
    );

    for (genvar i = 0; i < NUM_GLB_TILES; i++) begin : g_tile
        glb_tile u_tile (
            .clk              (clk),
            .arst_n           (arst_n),
            .tile_id          (TILE_ID_WIDTH'(i)),
            .proc_packet_wsti (packet_chain[i]),
            .proc_packet_esto (packet_chain[i+1]),
            .if_cfg_wst_s     (if_cfg_chain[i]),
            .if_cfg_est_m     (if_cfg_chain[i+1])
        );
    end

endmodule

// ==== hw/global_buffer_pkg.sv ====
package global_buffer_pkg;

    // Bank word and processor data width
    localparam int BANK_DATA_WIDTH   = 64;
    localparam int BANK_STRB_WIDTH   = BANK_DATA_WIDTH / 8;      // One strobe bit per byte
    localparam int BANK_WORDS        = 128;                      // Words in one tile's bank
    localparam int BANK_WORD_WIDTH   = $clog2(BANK_WORDS);       // Word index width
    localparam int BANK_BYTE_OFFSET  = $clog2(BANK_STRB_WIDTH);  // Byte bits below the word index

    localparam int GLB_ADDR_WIDTH    = 11;                       // Processor byte address
    localparam int NUM_GLB_TILES     = 2;                        // Tiles in the chain
    localparam int TILE_ID_WIDTH     = $clog2(NUM_GLB_TILES);
    localparam int TILE_SEL_LSB      = 10;                       // Address bit that picks the tile

    localparam int CFG_ADDR_WIDTH    = 8;
    localparam int CFG_DATA_WIDTH    = 32;
    localparam int CFG_TILE_SEL_LSB  = 4;                        // Config address bit for the tile
    localparam int CFG_REG_SEL_WIDTH = 2;                        // Low bits pick the register

    typedef struct packed {
        logic                       wr_en;
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    typedef struct packed {
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    typedef struct packed {
        logic                       rd_data_valid;
        logic [BANK_DATA_WIDTH-1:0] rd_data;
    } rdrs_packet_t;

    // Whole eastbound packet with the requests and the response riding along together
    typedef struct packed {
        wr_packet_t   wr;
        rdrq_packet_t rdrq;
        rdrs_packet_t rdrs;
    } packet_t;

    // Per tile configuration register map
    typedef enum logic [CFG_REG_SEL_WIDTH-1:0] {
        CFG_LOCK     = 2'd0,  // Bank write lock
        CFG_SCRATCH  = 2'd1,  // Free scratch word
        CFG_WR_COUNT = 2'd2,  // Accepted bank writes
        CFG_TILE_ID  = 2'd3   // Read-only tile index
    } glb_cfg_reg_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and search its output for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_global_buffer \
    -f global_buffer.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation passed" ||
{ echo "run_sim.sh: the run did not report a pass"; exit 1; }

// ==== verif/global_buffer_props.sv ====
`timescale 1ns/1ps

module global_buffer_props (
    input logic clk,
    input logic arst_n,
    input logic proc_rd_en,
    input logic proc_rd_data_valid,
    input logic cfg_rd_en,
    input logic cfg_rd_data_valid
);

    // A read passes the start register, both tiles and the return register
    a_proc_rd_latency: assert property (@(posedge clk) disable iff (!arst_n)
        proc_rd_data_valid == $past(proc_rd_en, 4))
        else $error("proc_rd_data_valid does not follow proc_rd_en by 4 cycles");

    a_cfg_rd_latency: assert property (@(posedge clk) disable iff (!arst_n)
        cfg_rd_data_valid == $past(cfg_rd_en))  // Tile config regs answer in one cycle
        else $error("cfg_rd_data_valid does not follow cfg_rd_en by 1 cycle");

    a_valid_in_reset: assert property (@(posedge clk)
        !arst_n |-> !proc_rd_data_valid && !cfg_rd_data_valid)
        else $error("a read valid is high while arst_n is low");

endmodule

// ==== verif/tb_global_buffer.sv ====
`timescale 1ns/1ps

module tb_global_buffer;
    import global_buffer_pkg::*;

    logic                       clk;
    logic                       arst_n;
    logic                       proc_wr_en;
    logic [BANK_STRB_WIDTH-1:0] proc_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]  proc_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] proc_wr_data;
    logic                       proc_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]  proc_rd_addr;
    logic [BANK_DATA_WIDTH-1:0] proc_rd_data;
    logic                       proc_rd_data_valid;
    logic                       cfg_wr_en;
    logic [CFG_ADDR_WIDTH-1:0]  cfg_wr_addr;
    logic [CFG_DATA_WIDTH-1:0]  cfg_wr_data;
    logic                       cfg_rd_en;
    logic [CFG_ADDR_WIDTH-1:0]  cfg_rd_addr;
    logic [CFG_DATA_WIDTH-1:0]  cfg_rd_data;
    logic                       cfg_rd_data_valid;

    logic [BANK_DATA_WIDTH-1:0] model_mem [NUM_GLB_TILES][BANK_WORDS];  // Reference bank contents
    int                         model_wr_count [NUM_GLB_TILES];         // Writes each tile accepts
    bit                         model_lock [NUM_GLB_TILES];
    logic [BANK_DATA_WIDTH-1:0] exp_data_q [$];                         // Responses still owed
    int                         exp_due_q [$];                          // Cycle each one is due
    logic [6:0]                 word_list [16];                         // Even entries on tile 0
    int                         cyc = 0;                                // Rising edges so far
    int                         errors = 0;
    int                         seed;

    global_buffer u_dut (
        .clk, .arst_n,
        .proc_wr_en, .proc_wr_strb, .proc_wr_addr, .proc_wr_data,
        .proc_rd_en, .proc_rd_addr, .proc_rd_data, .proc_rd_data_valid,
        .cfg_wr_en, .cfg_wr_addr, .cfg_wr_data, .cfg_rd_en, .cfg_rd_addr,
        .cfg_rd_data, .cfg_rd_data_valid
    );

    bind global_buffer global_buffer_props u_props (
        .clk(clk), .arst_n(arst_n), .proc_rd_en(proc_rd_en),
        .proc_rd_data_valid(proc_rd_data_valid), .cfg_rd_en(cfg_rd_en),
        .cfg_rd_data_valid(cfg_rd_data_valid)
    );

    always #20 clk = ~clk;                     // 40 ns period
    always @(posedge clk) cyc <= cyc + 1;

    // Read responses are matched against the expected queue on every falling edge
    always @(negedge clk) begin
        if (arst_n && proc_rd_data_valid) begin
            assert (exp_due_q.size() != 0 && exp_due_q[0] == cyc) else begin
                errors++;
                $display("%0t: read data came back with no read due in this cycle", $time);
            end
            if (exp_due_q.size() != 0 && exp_due_q[0] == cyc) begin
                assert (proc_rd_data === exp_data_q[0]) else begin
                    errors++;
                    $display("[ERROR] %0t proc_rd_data expected %h actual %h",
                             $time, exp_data_q[0], proc_rd_data);
                end
                void'(exp_data_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end else if (arst_n && exp_due_q.size() != 0) begin
            assert (exp_due_q[0] > cyc) else begin
                errors++;
                $display("%0t: read due at cycle %0d never returned data", $time, exp_due_q[0]);
                void'(exp_data_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
    end

    // Every strobe lasts one cycle unless the caller raises it again
    task automatic next_cycle();
        @(negedge clk);
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        cfg_wr_en  = 1'b0;
        cfg_rd_en  = 1'b0;
    endtask

    function automatic logic [GLB_ADDR_WIDTH-1:0] byte_addr(input int tile, input logic [6:0] word);
        logic [31:0] r;
        r = $random(seed);
        return {tile[0], word, r[2:0]};        // Low byte bits are random since the bank ignores them
    endfunction

    function automatic logic [CFG_ADDR_WIDTH-1:0] cfg_addr(input int tile, input glb_cfg_reg_e sel);
        return {3'b000, tile[0], 2'b00, sel};  // Bit 4 picks the tile
    endfunction

    task automatic proc_write(input int tile, input logic [6:0] word,
                              input logic [7:0] strb, input logic [63:0] data);
        next_cycle();
        proc_wr_en   = 1'b1;
        proc_wr_strb = strb;
        proc_wr_addr = byte_addr(tile, word);
        proc_wr_data = data;
        if (!model_lock[tile]) begin
            model_wr_count[tile]++;
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    model_mem[tile][word][b*8 +: 8] = data[b*8 +: 8];  // Byte merge
                end
            end
        end
    endtask

    task automatic proc_read(input int tile, input logic [6:0] word);
        next_cycle();
        proc_rd_en   = 1'b1;
        proc_rd_addr = byte_addr(tile, word);
        exp_data_q.push_back(model_mem[tile][word]);
        exp_due_q.push_back(cyc + NUM_GLB_TILES + 2);  // Start, every tile, then the return stage
    endtask

    task automatic drain_reads();
        while (exp_due_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic cfg_write(input int tile, input glb_cfg_reg_e sel, input logic [31:0] data);
        next_cycle();
        cfg_wr_en   = 1'b1;
        cfg_wr_addr = cfg_addr(tile, sel);
        cfg_wr_data = data;
    endtask

    task automatic cfg_read_check(input int tile, input glb_cfg_reg_e sel, input logic [31:0] exp);
        next_cycle();
        cfg_rd_en   = 1'b1;
        cfg_rd_addr = cfg_addr(tile, sel);
        next_cycle();
        assert (cfg_rd_data_valid) else begin
            errors++;
            $display("%0t: no config read response from tile %0d", $time, tile);
        end
        assert (cfg_rd_data === exp) else begin
            errors++;
            $display("[ERROR] %0t cfg_rd_data tile %0d %s expected %h actual %h",
                     $time, tile, sel.name(), exp, cfg_rd_data);
        end
    endtask

    task automatic test_full_writes();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            word_list[i] = r[6:0];
            proc_write(i % 2, word_list[i], 8'hff, {$random(seed), $random(seed)});
        end
        for (int i = 0; i < 16; i++) begin
            proc_read(i % 2, word_list[i]);
        end
        drain_reads();
    endtask

    task automatic test_partial_writes();
        logic [31:0] r;
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            proc_write(i % 2, word_list[i], r[7:0], {$random(seed), $random(seed)});
        end
        for (int i = 0; i < 6; i++) begin
            proc_read(i % 2, word_list[i]);
        end
        drain_reads();
    endtask

    // Index i*3 keeps the parity of i, so the tile alternates every cycle
    task automatic test_back_to_back_reads();
        for (int i = 0; i < 12; i++) begin
            proc_read(i % 2, word_list[(i * 3) % 16]);
        end
        drain_reads();
    endtask

    task automatic test_cfg_regs();
        logic [31:0] scratch [NUM_GLB_TILES];
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            cfg_read_check(t, CFG_TILE_ID, t);
            scratch[t] = $random(seed);
            cfg_write(t, CFG_SCRATCH, scratch[t]);
            cfg_read_check(t, CFG_SCRATCH, scratch[t]);
        end
        cfg_read_check(0, CFG_SCRATCH, scratch[0]);  // Tile 1 write must not reach tile 0
    endtask

    task automatic test_write_lock();
        cfg_write(1, CFG_LOCK, 32'd1);
        model_lock[1] = 1'b1;
        for (int i = 0; i < 6; i++) begin
            proc_write(i % 2, word_list[i], 8'hff, {$random(seed), $random(seed)});
        end
        cfg_read_check(1, CFG_LOCK, 32'd1);
        for (int i = 0; i < 6; i++) begin
            proc_read(i % 2, word_list[i]);
        end
        drain_reads();
        cfg_write(1, CFG_LOCK, 32'd0);
        model_lock[1] = 1'b0;
    endtask

    task automatic test_write_count();
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            cfg_read_check(t, CFG_WR_COUNT, model_wr_count[t]);
            cfg_write(t, CFG_WR_COUNT, 32'd0);
            model_wr_count[t] = 0;
            cfg_read_check(t, CFG_WR_COUNT, 32'd0);
        end
    endtask

    // About 90 requests at no more than 10 cycles each, plus reset and slack
    initial begin
        #((90 * 10 + 100) * 40);
        $display("%0t: watchdog expired before the tests finished", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed         = 32'h2deb;
        clk          = 1'b0;
        arst_n       = 1'b0;
        proc_wr_en   = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        cfg_wr_en    = 1'b0;
        cfg_wr_addr  = '0;
        cfg_wr_data  = '0;
        cfg_rd_en    = 1'b0;
        cfg_rd_addr  = '0;
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            model_wr_count[t] = 0;
            model_lock[t]     = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_full_writes();
        test_partial_writes();
        test_back_to_back_reads();
        test_cfg_regs();
        test_write_lock();
        test_write_count();
        repeat (2) next_cycle();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
